// File: ulpb.f
+incdir+common
+incdir+testbench
common/ulpb_pkg.sv
ulpb_node/ulpb_node.sv
logic/ulpb_ring_master.sv
logic/ulpb_ring.sv
testbench/tb_ulpb_ring.sv

// File: run_sim.sh
#!/bin/bash
# Builds the ring testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

TOP=tb_ulpb_ring
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module "$TOP" -f ulpb.f -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation PASSED"
exit 0

// File: testbench/tb_ulpb_ref.svh
`ifndef TB_ULPB_REF_SVH
`define TB_ULPB_REF_SVH

// a 32-bit Fibonacci LFSR with taps at 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// the LFSR steps once for every bit taken.
task automatic random_bits(input int count, output logic [31:0] value);
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
endtask

// the old word moves up one byte for each new byte and byte 0 becomes the highest new byte.
function automatic logic [`ULPB_DATA_WIDTH-1:0] expected_rx_data(
	input logic [`ULPB_DATA_WIDTH-1:0] prev,
	input logic [`ULPB_DATA_WIDTH-1:0] data,
	input logic [1:0]                  len
);
	logic [`ULPB_DATA_WIDTH-1:0] result;
	int nbytes;
	result = prev;
	nbytes = (len == 2'b00) ? 4 : int'(len);
	for (int i = 0; i < nbytes; i++)
		result = {result[`ULPB_DATA_WIDTH-9:0], data[8*i +: 8]};
	return result;
endfunction

task automatic compare_values(input string test_name, input logic [63:0] expected,
	input logic [63:0] actual);
	if (expected !== actual)
	begin
		$display("ERR %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
		$display("Errors found");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

`endif

// File: testbench/tb_ulpb_ring.sv
`timescale 1ns/1ps
`include "ulpb_settings.svh"

module tb_ulpb_ring;
	import ulpb_pkg::*;

	localparam int NODES = `ULPB_NODES;
	localparam int DW = `ULPB_DATA_WIDTH;
	localparam int AW = `ULPB_ADDR_WIDTH;
	localparam logic [NODES-1:0][AW-1:0] NODE_ADDRS = {8'h30, 8'h20, 8'h10};
	localparam logic [31:0] SEED = 32'd97683;
	localparam int TIMEOUT_CYCLES = 20 * 400;
	// idle, arbitration, the address, two toggle bits and the pause.
	localparam int NULL_FRAME_CYCLES = 2 + 4 * (AW + 2) + `ULPB_RESET_CNT;
	localparam int ACK_WAIT = 8;

	logic                     CLK;
	logic                     RESET;
	logic [NODES-1:0][AW-1:0] tx_addr;
	logic [NODES-1:0][DW-1:0] tx_data;
	len_code_t [NODES-1:0]    tx_len;
	logic [NODES-1:0]         tx_req;
	logic [NODES-1:0]         rx_ack;
	logic [NODES-1:0]         tx_ack;
	logic [NODES-1:0][AW-1:0] rx_addr;
	logic [NODES-1:0][DW-1:0] rx_data;
	logic [NODES-1:0]         rx_req;
	logic [NODES-1:0]         tx_acked;

	logic [31:0]   lfsr_state;
	int            ack_delay;
	int            issued;
	int            delivered;
	int            pend_dest [NODES];
	string         pend_name [NODES];
	logic [DW-1:0] model_data [NODES];
	logic          ack_pending [NODES];
	int            ack_left [NODES];

	// transfers in the order they won arbitration.
	int            xfer_dest[$];
	logic [DW-1:0] xfer_data[$];
	logic [1:0]    xfer_len[$];
	string         xfer_name[$];

	`include "tb_ulpb_ref.svh"

	ulpb_ring #(.NODE_ADDRS(NODE_ADDRS)) i_dut
	(
		.CLK      (CLK),
		.RESET    (RESET),
		.tx_addr  (tx_addr),
		.tx_data  (tx_data),
		.tx_len   (tx_len),
		.tx_req   (tx_req),
		.rx_ack   (rx_ack),
		.tx_ack   (tx_ack),
		.rx_addr  (rx_addr),
		.rx_data  (rx_data),
		.rx_req   (rx_req),
		.tx_acked (tx_acked)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$fatal(1, "timeout");
	end

	task automatic start_request(input int src, input int dest, input logic [DW-1:0] data,
		input logic [1:0] len, input string name);
		tx_addr[src] = NODE_ADDRS[dest];
		tx_data[src] = data;
		tx_len[src] = len_code_t'(len);
		tx_req[src] = 1'b1;
		pend_dest[src] = dest;
		pend_name[src] = name;
	endtask

	// winning arbitration clears the acknowledge of the previous frame.
	task automatic await_grant(input int src);
		while (!tx_ack[src])
			@(negedge CLK);
		compare_values({pend_name[src], " tx_acked_clear"}, 0, tx_acked[src]);
		xfer_dest.push_back(pend_dest[src]);
		xfer_data.push_back(tx_data[src]);
		xfer_len.push_back(tx_len[src]);
		xfer_name.push_back(pend_name[src]);
		issued++;
		tx_req[src] = 1'b0;
	endtask

	// the answer of the destination follows the end toggle by one bit.
	task automatic await_delivery(input int src);
		int waited;
		while (delivered < issued)
			@(negedge CLK);
		waited = 0;
		while (!tx_acked[src] && (waited < ACK_WAIT))
		begin
			@(negedge CLK);
			waited++;
		end
		compare_values({pend_name[src], " tx_acked"}, 1, tx_acked[src]);
	endtask

	task automatic transfer(input int src, input int dest, input logic [DW-1:0] data,
		input logic [1:0] len, input string name);
		@(negedge CLK);
		start_request(src, dest, data, len, name);
		await_grant(src);
		await_delivery(src);
	endtask

	task automatic accept_frame(input int n);
		logic [DW-1:0] expected;
		string name;
		if (xfer_dest.size() == 0)
		begin
			$display("node %0d raised rx_req with no transfer in flight", n);
			$display("Errors found");
			$fatal(1, "unexpected receive");
		end
		else
		begin
			name = xfer_name.pop_front();
			compare_values({name, " dest"}, xfer_dest.pop_front(), n);
			compare_values({name, " rx_addr"}, NODE_ADDRS[n], rx_addr[n]);
			expected = expected_rx_data(model_data[n], xfer_data.pop_front(),
				xfer_len.pop_front());
			compare_values({name, " rx_data"}, expected, rx_data[n]);
			model_data[n] = expected;
			delivered++;
			if (ack_delay == 0)
				rx_ack[n] = 1'b1;
			else
			begin
				ack_pending[n] = 1'b1;
				ack_left[n] = ack_delay;
			end
		end
	endtask

	initial
	begin : compare_proc
		rx_ack = '0;
		delivered = 0;
		for (int n = 0; n < NODES; n++)
		begin
			model_data[n] = '0;
			ack_pending[n] = 1'b0;
			ack_left[n] = 0;
		end
		forever
		begin
			@(negedge CLK);
			for (int n = 0; n < NODES; n++)
			begin
				if (rx_ack[n])
				begin
					compare_values("rx_req_release", 0, rx_req[n]);
					rx_ack[n] = 1'b0;
				end
				else if (ack_pending[n])
				begin
					compare_values("rx_req_held", 1, rx_req[n]);
					ack_left[n] = ack_left[n] - 1;
					if (ack_left[n] == 0)
					begin
						rx_ack[n] = 1'b1;
						ack_pending[n] = 1'b0;
					end
				end
				else if (rx_req[n])
					accept_frame(n);
			end
		end
	end

	initial
	begin : stimulus
		logic [31:0] data;
		logic [31:0] bits;
		logic [1:0]  len;
		int          src;
		int          dest;
		lfsr_state = SEED;
		ack_delay = 0;
		issued = 0;
		RESET = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		tx_req = '0;
		for (int n = 0; n < NODES; n++)
			tx_len[n] = LEN_4;
		repeat (3) @(negedge CLK);
		RESET = 1'b1;
		@(negedge CLK);
		compare_values("reset_tx_ack", 0, tx_ack);
		compare_values("reset_rx_req", 0, rx_req);
		compare_values("reset_tx_acked", 0, tx_acked);
		// the master keeps sending null frames while nobody requests.
		repeat (5 * NULL_FRAME_CYCLES) @(negedge CLK);
		compare_values("idle_rx_req", 0, rx_req);
		compare_values("idle_tx_acked", 0, tx_acked);

		random_bits(32, data);
		transfer(0, 2, data, 2'b00, "single_4byte");

		for (int i = 0; i < 8; i++)
		begin
			src = i % NODES;
			random_bits(1, bits);
			dest = (src + 1 + int'(bits[0])) % NODES;
			random_bits(32, data);
			len = i[1:0];
			if (i >= 4)
			begin
				random_bits(2, bits);
				len = bits[1:0];
			end
			transfer(src, dest, data, len, "all_lengths");
		end

		repeat (2)
		begin
			random_bits(32, data);
			random_bits(2, bits);
			transfer(2, 0, data, bits[1:0], "cross_master");
		end

		// nodes 1 and 2 ask in the same cycle and node 1 sits nearer the master.
		@(negedge CLK);
		random_bits(1, bits);
		dest = bits[0] ? 2 : 0;
		random_bits(32, data);
		random_bits(2, bits);
		start_request(1, dest, data, bits[1:0], "simultaneous_node1");
		random_bits(1, bits);
		dest = bits[0] ? 1 : 0;
		random_bits(32, data);
		random_bits(2, bits);
		start_request(2, dest, data, bits[1:0], "simultaneous_node2");
		await_grant(1);
		compare_values("simultaneous_order", 0, tx_ack[2]);
		await_delivery(1);
		await_grant(2);
		await_delivery(2);

		ack_delay = 2;
		random_bits(32, data);
		transfer(0, 1, data, 2'b11, "late_rx_ack");
		random_bits(32, data);
		transfer(2, 1, data, 2'b00, "late_rx_ack");
		ack_delay = 0;
		while ((rx_req != '0) || (rx_ack != '0))
			@(negedge CLK);

		$display("No errors");
		$finish;
	end

endmodule

// File: logic/ulpb_ring.sv
`timescale 1ns/1ps
`include "ulpb_settings.svh"

module ulpb_ring
#(
	parameter logic [`ULPB_NODES-1:0][`ULPB_ADDR_WIDTH-1:0] NODE_ADDRS = {8'h30, 8'h20, 8'h10}
)
(
	input  logic                                           CLK,
	input  logic                                           RESET,
	input  logic [`ULPB_NODES-1:0][`ULPB_ADDR_WIDTH-1:0]   tx_addr,
	input  logic [`ULPB_NODES-1:0][`ULPB_DATA_WIDTH-1:0]   tx_data,
	input  ulpb_pkg::len_code_t [`ULPB_NODES-1:0]          tx_len,
	input  logic [`ULPB_NODES-1:0]                         tx_req,
	input  logic [`ULPB_NODES-1:0]                         rx_ack,
	output logic [`ULPB_NODES-1:0]                         tx_ack,
	output logic [`ULPB_NODES-1:0][`ULPB_ADDR_WIDTH-1:0]   rx_addr,
	output logic [`ULPB_NODES-1:0][`ULPB_DATA_WIDTH-1:0]   rx_data,
	output logic [`ULPB_NODES-1:0]                         rx_req,
	output logic [`ULPB_NODES-1:0]                         tx_acked
);

	// link[0] leaves the master, link[n+1] leaves node n.
	logic [`ULPB_NODES:0] link;

	ulpb_ring_master i_master
	(
		.CLK      (CLK),
		.RESET    (RESET),
		.ring_in  (link[`ULPB_NODES]),
		.ring_out (link[0])
	);

	for (genvar n = 0; n < `ULPB_NODES; n++)
	begin : g_node
		ulpb_node #(.ADDRESS(NODE_ADDRS[n])) i_node
		(
			.CLK      (CLK),
			.RESET    (RESET),
			.din      (link[n]),
			.dout     (link[n+1]),
			.tx_addr  (tx_addr[n]),
			.tx_data  (tx_data[n]),
			.tx_len   (tx_len[n]),
			.tx_req   (tx_req[n]),
			.tx_ack   (tx_ack[n]),
			.rx_addr  (rx_addr[n]),
			.rx_data  (rx_data[n]),
			.rx_req   (rx_req[n]),
			.rx_ack   (rx_ack[n]),
			.tx_acked (tx_acked[n])
		);
	end

endmodule

// File: logic/ulpb_ring_master.sv
`timescale 1ns/1ps
`include "ulpb_settings.svh"

module ulpb_ring_master
(
	input  logic CLK,
	input  logic RESET,
	input  logic ring_in,
	output logic ring_out
);
	import ulpb_pkg::*;

	localparam int AW = `ULPB_ADDR_WIDTH;
	localparam int CW = $clog2(AW + 1);
	localparam int RW = $clog2(`ULPB_RESET_CNT + 1);
	localparam logic [AW-1:0] NULL_ADDR = `ULPB_NULL_ADDR;
	localparam logic [RW-1:0] RST_LOAD = RW'(`ULPB_RESET_CNT - 1);

	bus_phase_t    phase;
	logic          owned;
	logic          end_seen;
	logic [1:0]    samp;
	logic [CW-1:0] addr_left;
	logic [AW-1:0] addr_sr;
	logic [RW-1:0] reset_cnt;
	logic          second_half;
	logic          null_bit;

	assign second_half = (phase == DRIVE2) || (phase == LATCH2);

	// the null frame sends the address bits and then a low-high and a high-low toggle.
	assign null_bit = (addr_left != '0) ? addr_sr[AW-1] : (end_seen ^ second_half);

	// a constant level between frames keeps the ring from closing on itself.
	always_comb
	begin
		case (phase)
			BUS_IDLE, BUS_RESET: ring_out = 1'b1;
			default: ring_out = owned ? ring_in : null_bit;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (phase == BUS_IDLE)
			addr_sr <= NULL_ADDR;
		else if ((phase == LATCH2) && (addr_left != '0))
			addr_sr <= {addr_sr[AW-2:0], 1'b0};
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= BUS_IDLE;
			owned <= 1'b0;
			end_seen <= 1'b0;
			samp <= '0;
			addr_left <= '0;
			reset_cnt <= '0;
		end
		else
		begin
			if ((phase == DRIVE1) || (phase == DRIVE2))
				samp <= {samp[0], ring_in};
			case (phase)
				BUS_IDLE:
				begin
					// a low ring here means some node pulled it for arbitration.
					owned <= ~ring_in;
					end_seen <= 1'b0;
					addr_left <= CW'(AW);
					phase <= ARBI_RESOLVED;
				end
				ARBI_RESOLVED: phase <= DRIVE1;
				DRIVE1: phase <= LATCH1;
				LATCH1: phase <= DRIVE2;
				DRIVE2: phase <= LATCH2;
				LATCH2:
				begin
					if (end_seen)
					begin
						phase <= BUS_RESET;
						reset_cnt <= RST_LOAD;
					end
					else
					begin
						phase <= DRIVE1;
						if (samp[1] ^ samp[0])
							end_seen <= 1'b1;
						if (addr_left != '0)
							addr_left <= addr_left - 1'b1;
					end
				end
				BUS_RESET:
				begin
					if (reset_cnt == '0)
						phase <= BUS_IDLE;
					else
						reset_cnt <= reset_cnt - 1'b1;
				end
				default: phase <= BUS_IDLE;
			endcase
		end
	end

endmodule

// File: ulpb_node/ulpb_node.sv
`timescale 1ns/1ps
`include "ulpb_settings.svh"

module ulpb_node
#(
	parameter logic [`ULPB_ADDR_WIDTH-1:0] ADDRESS = 8'h10
)
(
	input  logic                        CLK,
	input  logic                        RESET,
	input  logic                        din,
	output logic                        dout,
	input  logic [`ULPB_ADDR_WIDTH-1:0] tx_addr,
	input  logic [`ULPB_DATA_WIDTH-1:0] tx_data,
	input  ulpb_pkg::len_code_t         tx_len,
	input  logic                        tx_req,
	output logic                        tx_ack,
	output logic [`ULPB_ADDR_WIDTH-1:0] rx_addr,
	output logic [`ULPB_DATA_WIDTH-1:0] rx_data,
	output logic                        rx_req,
	input  logic                        rx_ack,
	output logic                        tx_acked
);
	import ulpb_pkg::*;

	localparam int AW = `ULPB_ADDR_WIDTH;
	localparam int DW = `ULPB_DATA_WIDTH;
	localparam int AB = $clog2(AW);
	localparam int BW = $clog2(DW);
	localparam int RW = $clog2(`ULPB_RESET_CNT + 1);
	localparam logic [RW-1:0] RST_LOAD = RW'(`ULPB_RESET_CNT - 1);

	// transmit segments of a frame.
	localparam logic [1:0] SEG_ADDR = 2'd0;
	localparam logic [1:0] SEG_DATA = 2'd1;
	localparam logic [1:0] SEG_TOG  = 2'd2;

	bus_phase_t      phase;
	node_mode_t      mode;
	logic [1:0]      seg;
	logic            end_seen;
	logic [1:0]      samp;
	logic [BW-1:0]   bit_pos;
	logic [AB-1:0]   addr_cnt;
	logic            addr_rcvd;
	logic [RW-1:0]   reset_cnt;
	logic [AW-1:0]   addr_q;
	logic [DW-1:0]   data_q;
	len_code_t       len_q;
	logic [AW-1:0]   addr_shift;
	logic            want;
	logic            win;
	logic            second_half;
	logic            toggle;
	logic            rx_shift;
	logic            tx_bit;

	// byte 0 lands in the top used byte, so it goes out first.
	function automatic logic [DW-1:0] reorder(input logic [DW-1:0] d, input len_code_t len);
		logic [DW-1:0] r;
		case (len)
			LEN_1: r = {{(DW-8){1'b0}}, d[7:0]};
			LEN_2: r = {{(DW-16){1'b0}}, d[7:0], d[15:8]};
			LEN_3: r = {{(DW-24){1'b0}}, d[7:0], d[15:8], d[23:16]};
			default: r = {d[7:0], d[15:8], d[23:16], d[31:24]};
		endcase
		return r;
	endfunction

	function automatic logic [BW-1:0] top_bit(input len_code_t len);
		logic [BW-1:0] t;
		case (len)
			LEN_1: t = BW'(7);
			LEN_2: t = BW'(15);
			LEN_3: t = BW'(23);
			default: t = BW'(DW - 1);
		endcase
		return t;
	endfunction

	assign want = tx_req & ~tx_ack;
	assign win = (phase == BUS_IDLE) & want & din;
	assign second_half = (phase == DRIVE2) || (phase == LATCH2);
	assign toggle = samp[1] ^ samp[0];
	assign rx_shift = (phase == LATCH2) && (mode == MODE_RX) && !end_seen && !toggle;

	// the end toggle of the transmitter goes low then high within one bit.
	always_comb
	begin
		case (seg)
			SEG_ADDR: tx_bit = addr_q[bit_pos[AB-1:0]];
			SEG_DATA: tx_bit = data_q[bit_pos];
			default: tx_bit = second_half;
		endcase
	end

	always_comb
	begin
		dout = din;
		case (phase)
			BUS_IDLE:
			begin
				dout = din & ~want;
			end
			ARBI_RESOLVED:
			begin
				if (mode == MODE_TX)
					dout = 1'b0;
			end
			DRIVE1, LATCH1, DRIVE2, LATCH2:
			begin
				if ((mode == MODE_TX) && !end_seen)
					dout = tx_bit;
				// the receiver answers high then low, which breaks the loop as well.
				else if ((mode == MODE_RX) && end_seen)
					dout = ~second_half;
			end
			default:
			begin
				dout = din;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (win)
		begin
			addr_q <= tx_addr;
			data_q <= reorder(tx_data, tx_len);
			len_q <= tx_len;
		end
		if (rx_shift && !addr_rcvd)
			addr_shift <= {addr_shift[AW-2:0], samp[0]};
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= BUS_IDLE;
			mode <= MODE_IDLE;
			seg <= SEG_ADDR;
			end_seen <= 1'b0;
			samp <= '0;
			bit_pos <= '0;
			addr_cnt <= '0;
			addr_rcvd <= 1'b0;
			reset_cnt <= '0;
			tx_ack <= 1'b0;
			tx_acked <= 1'b0;
			rx_req <= 1'b0;
			rx_addr <= '0;
			rx_data <= '0;
		end
		else
		begin
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
			if (rx_req && rx_ack)
				rx_req <= 1'b0;
			if ((phase == DRIVE1) || (phase == DRIVE2))
				samp <= {samp[0], din};

			case (phase)
				BUS_IDLE:
				begin
					mode <= win ? MODE_TX : MODE_RX;
					if (want)
						tx_acked <= 1'b0;
					if (win)
						tx_ack <= 1'b1;
					seg <= SEG_ADDR;
					bit_pos <= BW'(AW - 1);
					addr_cnt <= AB'(AW - 1);
					phase <= ARBI_RESOLVED;
				end
				ARBI_RESOLVED:
				begin
					phase <= DRIVE1;
				end
				DRIVE1:
				begin
					if ((mode == MODE_RX) && addr_rcvd && (addr_shift != ADDRESS))
						mode <= MODE_FWD;
					phase <= LATCH1;
				end
				LATCH1:
				begin
					phase <= DRIVE2;
				end
				DRIVE2:
				begin
					phase <= LATCH2;
				end
				LATCH2:
				begin
					if (end_seen)
					begin
						phase <= BUS_RESET;
						reset_cnt <= RST_LOAD;
						if (mode == MODE_TX)
							tx_acked <= toggle;
					end
					else
					begin
						phase <= DRIVE1;
						case (mode)
							MODE_TX:
							begin
								if (seg == SEG_TOG)
									end_seen <= 1'b1;
								else if (bit_pos != '0)
									bit_pos <= bit_pos - 1'b1;
								else if (seg == SEG_ADDR)
								begin
									seg <= SEG_DATA;
									bit_pos <= top_bit(len_q);
								end
								else
									seg <= SEG_TOG;
							end
							MODE_RX:
							begin
								if (toggle)
								begin
									end_seen <= 1'b1;
									rx_req <= 1'b1;
									rx_addr <= addr_shift;
								end
								else if (!addr_rcvd)
								begin
									if (addr_cnt == '0)
										addr_rcvd <= 1'b1;
									else
										addr_cnt <= addr_cnt - 1'b1;
								end
								else
									rx_data <= {rx_data[DW-2:0], samp[0]};
							end
							MODE_FWD:
							begin
								if (toggle)
									end_seen <= 1'b1;
							end
							default:
							begin
								end_seen <= 1'b0;
							end
						endcase
					end
				end
				BUS_RESET:
				begin
					if (reset_cnt == '0)
					begin
						phase <= BUS_IDLE;
						mode <= MODE_IDLE;
						end_seen <= 1'b0;
						addr_rcvd <= 1'b0;
					end
					else
						reset_cnt <= reset_cnt - 1'b1;
				end
				default:
				begin
					phase <= BUS_IDLE;
				end
			endcase
		end
	end

endmodule

// File: common/ulpb_pkg.sv
package ulpb_pkg;

	// phase of a frame; every node and the ring master step through it together.
	typedef enum logic [2:0]
	{
		BUS_IDLE      = 3'd0,
		ARBI_RESOLVED = 3'd1,
		DRIVE1        = 3'd2,
		LATCH1        = 3'd3,
		DRIVE2        = 3'd4,
		LATCH2        = 3'd5,
		BUS_RESET     = 3'd6
	} bus_phase_t;

	// role a node takes for the current frame.
	typedef enum logic [1:0]
	{
		MODE_IDLE = 2'd0,
		MODE_TX   = 2'd1,
		MODE_RX   = 2'd2,
		MODE_FWD  = 2'd3
	} node_mode_t;

	// payload length in bytes; four bytes wraps to zero.
	typedef enum logic [1:0]
	{
		LEN_4 = 2'b00,
		LEN_1 = 2'b01,
		LEN_2 = 2'b10,
		LEN_3 = 2'b11
	} len_code_t;

endpackage

// File: common/ulpb_settings.svh
`ifndef ULPB_SETTINGS_SVH
`define ULPB_SETTINGS_SVH

// ring geometry.
`define ULPB_ADDR_WIDTH 8
`define ULPB_DATA_WIDTH 32
`define ULPB_NODES 3

// cycles the ring rests between two frames.
`define ULPB_RESET_CNT 4

// no node may hold this address; the master sends it when the ring is quiet.
`define ULPB_NULL_ADDR {`ULPB_ADDR_WIDTH{1'b1}}

`endif
